/* Makefile */
# verilator build and run of the rv64i subset core
VERILATOR ?= verilator
TOP       ?= rv_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* hw/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,      // synchronous, pc back to 0
    output logic [`RV_IMEM_AW-1:0] imem_addr,  // instruction word index
    input  logic [31:0]            imem_rdata, // combinational fetch
    output logic [`RV_DMEM_AW-1:0] dmem_addr,  // doubleword index
    output logic [`RV_XLEN-1:0]    dmem_wdata,
    output logic                   dmem_we,    // written on the next rising edge
    input  logic [`RV_XLEN-1:0]    dmem_rdata
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] next_pc;
    logic [4:0]          rs1, rs2, rd;
    logic [`RV_XLEN-1:0] imm;
    alu_op_e             alu_op;
    logic                alu_src_imm;
    logic                reg_we_dec;  // decode view, before reset gating
    logic                reg_we;      // gated, goes to the register file
    logic                mem_we;
    wb_sel_e             wb_sel;
    logic                branch, branch_ne;
    logic [`RV_XLEN-1:0] rdata1, rdata2;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] wb_data;

    // program counter, one instruction per clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0; // boot address
        end else begin
            pc <= next_pc;
        end
    end

    assign imem_addr = pc[2 +: `RV_IMEM_AW]; // word aligned fetch

    rv_decode u_decode (
        .instr(imem_rdata), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .alu_op(alu_op), .alu_src_imm(alu_src_imm), .reg_we(reg_we_dec),
        .mem_we(mem_we), .wb_sel(wb_sel), .branch(branch), .branch_ne(branch_ne)
    );

    rv_regfile u_regfile (
        .clk(clk), .rs1(rs1), .rs2(rs2), .rd(rd), .we(reg_we), .wdata(wb_data),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    rv_execute u_execute (
        .pc(pc), .rdata1(rdata1), .rdata2(rdata2), .imm(imm), .alu_op(alu_op),
        .alu_src_imm(alu_src_imm), .branch(branch), .branch_ne(branch_ne),
        .alu_result(alu_result), .next_pc(next_pc)
    );

    // memory port and write-back, also masks writes during reset
    rv_result u_result (
        .rst_n(rst_n), .alu_result(alu_result), .rdata2(rdata2), .mem_we(mem_we),
        .wb_sel(wb_sel), .reg_we_dec(reg_we_dec), .dmem_rdata(dmem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .wb_data(wb_data), .reg_we(reg_we)
    );

endmodule

`default_nettype wire

/* hw/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic [31:0]         instr,       // instruction word from imem
    output logic [4:0]          rs1,         // source register a
    output logic [4:0]          rs2,         // source register b
    output logic [4:0]          rd,          // destination register
    output logic [`RV_XLEN-1:0] imm,         // sign-extended immediate
    output alu_op_e             alu_op,
    output logic                alu_src_imm, // operand b from imm
    output logic                reg_we,      // write rd, before reset gating
    output logic                mem_we,      // sd
    output wb_sel_e             wb_sel,
    output logic                branch,      // beq or bne
    output logic                branch_ne    // invert the zero test
);

    // funct3 codes shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    opcode_e             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b;

    // sub only exists for register operands, funct7 bit 5 picks it
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = sub ? ALU_SUB : ALU_ADD;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD; // shifts are not part of the subset
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // immediate formats, bit 31 is always the sign
    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        // defaults make any unknown opcode a no-op
        imm         = imm_i;
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        reg_we      = 1'b0;
        mem_we      = 1'b0;
        wb_sel      = WB_ALU;
        branch      = 1'b0;
        branch_ne   = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op = arith_op(funct3, funct7[5]);
                reg_we = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op      = arith_op(funct3, 1'b0); // imm bit 30 is data here
                alu_src_imm = 1'b1;
                reg_we      = 1'b1;
            end
            OPC_LOAD: begin
                alu_src_imm = 1'b1; // rs1 + offset
                reg_we      = 1'b1;
                wb_sel      = WB_MEM;
            end
            OPC_STORE: begin
                imm         = imm_s;
                alu_src_imm = 1'b1;
                mem_we      = 1'b1;
            end
            OPC_BRANCH: begin
                imm       = imm_b;
                alu_op    = ALU_SUB;                  // rs1 - rs2, zero when equal
                branch    = (funct3[2:1] == 2'b00);   // beq 000, bne 001 only
                branch_ne = funct3[0];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_execute
    import rv_pkg::*;
(
    input  logic [`RV_XLEN-1:0] pc,          // address of this instruction
    input  logic [`RV_XLEN-1:0] rdata1,      // rs1 value, operand a
    input  logic [`RV_XLEN-1:0] rdata2,      // rs2 value
    input  logic [`RV_XLEN-1:0] imm,
    input  alu_op_e             alu_op,
    input  logic                alu_src_imm,
    input  logic                branch,
    input  logic                branch_ne,
    output logic [`RV_XLEN-1:0] alu_result,
    output logic [`RV_XLEN-1:0] next_pc
);

    logic [`RV_XLEN-1:0] op_b;        // second alu operand after the select
    logic                lt_signed;   // slt
    logic                lt_unsigned; // sltu
    logic                zero;        // alu result is all zeros
    logic                taken;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_target;

    // operand select stage
    assign op_b = alu_src_imm ? imm : rdata2;

    assign lt_signed   = $signed(rdata1) < $signed(op_b);
    assign lt_unsigned = rdata1 < op_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = rdata1 + op_b;
            ALU_SUB:  alu_result = rdata1 - op_b;
            ALU_AND:  alu_result = rdata1 & op_b;
            ALU_OR:   alu_result = rdata1 | op_b;
            ALU_XOR:  alu_result = rdata1 ^ op_b;
            ALU_SLT:  alu_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            default:  alu_result = rdata1 + op_b; // unused encodings behave as add
        endcase
    end

    // flags
    assign zero = (alu_result == '0);

    // beq takes on zero, bne on not zero
    assign taken = branch & (zero ^ branch_ne);

    // next program counter, offset is relative to this instruction
    assign pc_plus4  = pc + `RV_XLEN'd4;
    assign pc_target = pc + imm;
    assign next_pc   = taken ? pc_target : pc_plus4;

endmodule

`default_nettype wire

/* hw/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // major opcodes of the supported subset, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // add sub and or xor slt sltu
        OPC_OP_IMM = 7'b0010011, // addi andi ori xori
        OPC_LOAD   = 7'b0000011, // ld
        OPC_STORE  = 7'b0100011, // sd
        OPC_BRANCH = 7'b1100011  // beq bne
    } opcode_e;

    // operation selected for the alu
    // loads and stores compute their address with ALU_ADD,
    // branches compare with ALU_SUB and look at the zero flag
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5, // signed less-than
        ALU_SLTU = 4'd6  // unsigned less-than
    } alu_op_e;

    // source of the register file write data
    typedef enum logic {
        WB_ALU = 1'b0, // alu result
        WB_MEM = 1'b1  // data memory read, ld only
    } wb_sel_e;

endpackage

`default_nettype wire

/* hw/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_regfile (
    input  logic                clk,
    input  logic [4:0]          rs1,    // read port a index
    input  logic [4:0]          rs2,    // read port b index
    input  logic [4:0]          rd,     // write index
    input  logic                we,     // already low during reset
    input  logic [`RV_XLEN-1:0] wdata,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS]; // no reset, contents undefined at boot

    // one write per cycle, x0 never stored
    always_ff @(posedge clk) begin
        if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // reads are combinational and see the value from before this edge
    // x0 is forced so the unwritten entry 0 is never seen
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* hw/rv_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_result
    import rv_pkg::*;
(
    input  logic                  rst_n,
    input  logic [`RV_XLEN-1:0]   alu_result, // address for ld and sd
    input  logic [`RV_XLEN-1:0]   rdata2,     // store data from rs2
    input  logic                  mem_we,     // sd from decode
    input  wb_sel_e               wb_sel,
    input  logic                  reg_we_dec, // rd write from decode
    input  logic [`RV_XLEN-1:0]   dmem_rdata,
    output logic [`RV_DMEM_AW-1:0] dmem_addr,
    output logic [`RV_XLEN-1:0]   dmem_wdata,
    output logic                  dmem_we,
    output logic [`RV_XLEN-1:0]   wb_data,
    output logic                  reg_we
);

    // doubleword index, low three bits are the byte offset inside it
    assign dmem_addr  = alu_result[3 +: `RV_DMEM_AW];
    assign dmem_wdata = rdata2;

    // no architectural write while the core is held in reset
    assign dmem_we = mem_we & rst_n;
    assign reg_we  = reg_we_dec & rst_n;

    // write-back select
    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = dmem_rdata; // ld
            default: wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// register and datapath width, RV64
`define RV_XLEN 64

// architectural registers x0 to x31
`define RV_NREGS 32

// instruction memory word index, taken from pc bits 7:2
`define RV_IMEM_AW 6

// data memory doubleword index, taken from alu result bits 8:3
`define RV_DMEM_AW 6

`endif

/* project.f */
+incdir+hw
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core.sv
sim/rv_assertions.sv
sim/rv_checker.sv
sim/rv_tb.sv

/* sim/rv_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic [`RV_IMEM_AW-1:0] imem_addr,
    input logic                   dmem_we,
    input logic [`RV_XLEN-1:0]    dmem_wdata
);

    // no store may leave the core while it is held in reset
    we_low_in_reset: assert property (@(posedge clk) !rst_n |-> !dmem_we)
        else $error("dmem_we high while rst_n low");

    // the edge with rst_n low brings the pc back to the boot address
    pc_zero_after_reset: assert property (@(posedge clk) !rst_n |=> (imem_addr == '0))
        else $error("imem_addr not zero after a reset cycle");

    // store data must be fully defined
    wdata_known: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we |-> !$isunknown(dmem_wdata))
        else $error("dmem_wdata unknown during a store");

endmodule

`default_nettype wire

/* sim/rv_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   dmem_we,
    input logic [`RV_DMEM_AW-1:0] dmem_addr,
    input logic [`RV_XLEN-1:0]    dmem_wdata
);

    logic [`RV_DMEM_AW-1:0] exp_addr_q [$]; // expected stores, program order
    logic [`RV_XLEN-1:0]    exp_data_q [$];
    logic [`RV_DMEM_AW-1:0] exp_a;
    logic [`RV_XLEN-1:0]    exp_d;
    int                     error_count = 0;
    int                     write_count = 0;

    task automatic push_expected(input logic [`RV_DMEM_AW-1:0] addr,
                                 input logic [`RV_XLEN-1:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    // sampled mid cycle, the write itself lands on the next rising edge
    always @(negedge clk) begin
        if (!rst_n) begin
            if (dmem_we) begin
                $display("data memory write enabled during reset at %0t", $time);
                error_count++;
            end
        end else if (dmem_we) begin
            write_count++;
            if (exp_addr_q.size() == 0) begin
                $display("extra data memory write at %0t to address %0d", $time, dmem_addr);
                error_count++;
            end else begin
                exp_a = exp_addr_q.pop_front();
                exp_d = exp_data_q.pop_front();
                if (dmem_addr !== exp_a) begin
                    $display("Error: time %0t dmem_addr got %0d expected %0d",
                             $time, dmem_addr, exp_a);
                    error_count++;
                end
                if (dmem_wdata !== exp_d) begin
                    $display("Error: time %0t dmem_wdata got %h expected %h",
                             $time, dmem_wdata, exp_d);
                    error_count++;
                end
            end
        end
    end

    // anything still queued never got written
    task automatic report(output int errors);
        while (exp_addr_q.size() > 0) begin
            exp_a = exp_addr_q.pop_front();
            exp_d = exp_data_q.pop_front();
            $display("missing data memory write to address %0d of value %h", exp_a, exp_d);
            error_count++;
        end
        $display("checker: %0d writes seen, %0d errors", write_count, error_count);
        errors = error_count;
    endtask

endmodule

`default_nettype wire

/* sim/rv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_tb;

    localparam int T_ADD = 0, T_SUB = 1, T_AND = 2, T_OR = 3, T_XOR = 4;
    localparam int T_SLT = 5, T_SLTU = 6, T_ADDI = 7, T_XORI = 8, T_ANDI = 9;
    localparam int T_COPY = 10, T_X0 = 11, T_BEQ = 12, T_BNE = 13;
    localparam int NROWS = 16;
    localparam int HALT_WORD = 63; // last imem word, branch to itself
    localparam int TMP_SLOT = 48;  // scratch doubleword for the copy row

    typedef struct {
        int          op;
        bit          rnd;  // operands drawn from the lcg
        logic [63:0] a, b; // b is the 12-bit immediate for i-type rows
    } row_t;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    logic [`RV_IMEM_AW-1:0] imem_addr;
    logic [31:0]            imem_rdata;
    logic [`RV_DMEM_AW-1:0] dmem_addr;
    logic [`RV_XLEN-1:0]    dmem_wdata;
    logic                   dmem_we;
    logic [`RV_XLEN-1:0]    dmem_rdata;
    logic [31:0]            imem [2**`RV_IMEM_AW];
    logic [`RV_XLEN-1:0]    dmem [2**`RV_DMEM_AW];
    row_t                   rows [NROWS];
    logic [63:0]            lcg_state = 64'd52;
    int                     n_instr = 0;
    bit                     built = 1'b0;

    always #10 clk = ~clk; // 20 ns period

    // memory models, combinational reads
    assign imem_rdata = imem[imem_addr];
    assign dmem_rdata = dmem[dmem_addr];
    always @(posedge clk) if (dmem_we) dmem[dmem_addr] <= dmem_wdata;

    rv_core DUT (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata)
    );

    rv_checker u_checker (
        .clk(clk), .rst_n(rst_n), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata)
    );

    bind rv_core rv_assertions u_assertions (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .dmem_we(dmem_we),
        .dmem_wdata(dmem_wdata)
    );

    function automatic logic [63:0] lcg_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_sd(input logic [4:0] rs2, input logic [11:0] ofs);
        return {ofs[11:5], rs2, 5'd0, 3'b011, ofs[4:0], 7'b0100011}; // base is x0
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                          input logic [12:0] ofs);
        return {ofs[12], ofs[10:5], rs2, rs1, f3, ofs[4:1], ofs[11], 7'b1100011};
    endfunction

    // reference results straight from the isa definitions
    function automatic logic [63:0] expect_alu(input int op, input logic [63:0] a, b);
        logic [63:0] imm;
        imm = {{52{b[11]}}, b[11:0]}; // i-type sign extension
        case (op)
            T_ADD:   return a + b;
            T_SUB:   return a - b;
            T_AND:   return a & b;
            T_OR:    return a | b;
            T_XOR:   return a ^ b;
            T_SLT:   return {63'd0, $signed(a) < $signed(b)};
            T_SLTU:  return {63'd0, a < b};
            T_ADDI:  return a + imm;
            T_XORI:  return a ^ imm;
            default: return a & imm; // andi
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[n_instr] = w;
        n_instr++;
    endtask

    task automatic fill_table();
        rows[0]  = '{T_ADD,  1'b1, 64'd0, 64'd0};
        rows[1]  = '{T_SUB,  1'b0, 64'd5, 64'd9}; // goes negative
        rows[2]  = '{T_AND,  1'b1, 64'd0, 64'd0};
        rows[3]  = '{T_OR,   1'b0, 64'hF0F0_0000_1234_0000, 64'h0F00_ABCD_0000_0001};
        rows[4]  = '{T_XOR,  1'b1, 64'd0, 64'd0};
        rows[5]  = '{T_SLT,  1'b0, 64'hFFFF_FFFF_FFFF_FFFD, 64'd2}; // -3 < 2
        rows[6]  = '{T_SLTU, 1'b0, 64'hFFFF_FFFF_FFFF_FFFD, 64'd2}; // huge, not less
        rows[7]  = '{T_ADDI, 1'b0, 64'd100, 64'hFF9};               // -7
        rows[8]  = '{T_XORI, 1'b0, 64'h1234, 64'hFFF};              // -1
        rows[9]  = '{T_ANDI, 1'b0, 64'h8765_4321_0FED_CBA9, 64'hFF0};
        rows[10] = '{T_COPY, 1'b0, 64'hCAFE_F00D_DEAD_BEEF, 64'd0};
        rows[11] = '{T_X0,   1'b0, 64'd0, 64'd0};
        rows[12] = '{T_BEQ,  1'b0, 64'd7, 64'd7}; // taken
        rows[13] = '{T_BEQ,  1'b0, 64'd7, 64'd8};
        rows[14] = '{T_BNE,  1'b0, 64'd1, 64'd2}; // taken
        rows[15] = '{T_BNE,  1'b0, 64'd3, 64'd3};
    endtask

    // program builder, also feeds the checker in store order
    task automatic build_program();
        logic [63:0] a, b;
        logic [11:0] oa, ob, ores, omark;
        bit          taken;
        for (int i = 0; i < NROWS; i++) begin
            a = rows[i].rnd ? lcg_next() : rows[i].a;
            b = rows[i].rnd ? lcg_next() : rows[i].b;
            dmem[2*i] = a;
            dmem[2*i+1] = b;
            oa = 12'(16*i);
            ob = 12'(16*i + 8);
            ores = 12'(8*(32 + i));
            omark = 12'(8*(TMP_SLOT + i));
            case (rows[i].op)
                T_COPY: begin
                    emit(enc_i(7'b0000011, 3'b011, 5'd1, 5'd0, oa));
                    emit(enc_sd(5'd1, 12'(8*TMP_SLOT)));
                    emit(enc_i(7'b0000011, 3'b011, 5'd3, 5'd0, 12'(8*TMP_SLOT)));
                    emit(enc_sd(5'd3, ores));
                    u_checker.push_expected(6'(TMP_SLOT), a);
                    u_checker.push_expected(6'(32 + i), a);
                end
                T_X0: begin
                    emit(enc_r(7'd0, 3'b000, 5'd0, 5'd1, 5'd1)); // add x0, x1, x1
                    emit(enc_sd(5'd0, ores));
                    u_checker.push_expected(6'(32 + i), 64'd0);
                end
                T_BEQ, T_BNE: begin
                    taken = (rows[i].op == T_BEQ) ? (a == b) : (a != b);
                    emit(enc_i(7'b0000011, 3'b011, 5'd1, 5'd0, oa));
                    emit(enc_i(7'b0000011, 3'b011, 5'd2, 5'd0, ob));
                    emit(enc_b((rows[i].op == T_BEQ) ? 3'b000 : 3'b001, 5'd1, 5'd2, 13'd8));
                    emit(enc_sd(5'd1, omark)); // skipped when taken
                    emit(enc_sd(5'd2, ores));
                    if (!taken) u_checker.push_expected(6'(TMP_SLOT + i), a);
                    u_checker.push_expected(6'(32 + i), b);
                end
                T_ADDI, T_XORI, T_ANDI: begin
                    emit(enc_i(7'b0000011, 3'b011, 5'd1, 5'd0, oa));
                    emit(enc_i(7'b0010011, (rows[i].op == T_ADDI) ? 3'b000 :
                               (rows[i].op == T_XORI) ? 3'b100 : 3'b111,
                               5'd3, 5'd1, b[11:0]));
                    emit(enc_sd(5'd3, ores));
                    u_checker.push_expected(6'(32 + i), expect_alu(rows[i].op, a, b));
                end
                default: begin
                    emit(enc_i(7'b0000011, 3'b011, 5'd1, 5'd0, oa));
                    emit(enc_i(7'b0000011, 3'b011, 5'd2, 5'd0, ob));
                    case (rows[i].op)
                        T_SUB:   emit(enc_r(7'h20, 3'b000, 5'd3, 5'd1, 5'd2));
                        T_AND:   emit(enc_r(7'h00, 3'b111, 5'd3, 5'd1, 5'd2));
                        T_OR:    emit(enc_r(7'h00, 3'b110, 5'd3, 5'd1, 5'd2));
                        T_XOR:   emit(enc_r(7'h00, 3'b100, 5'd3, 5'd1, 5'd2));
                        T_SLT:   emit(enc_r(7'h00, 3'b010, 5'd3, 5'd1, 5'd2));
                        T_SLTU:  emit(enc_r(7'h00, 3'b011, 5'd3, 5'd1, 5'd2));
                        default: emit(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
                    endcase
                    emit(enc_sd(5'd3, ores));
                    u_checker.push_expected(6'(32 + i), expect_alu(rows[i].op, a, b));
                end
            endcase
        end
        emit(enc_b(3'b000, 5'd0, 5'd0, 13'd0)); // halt loop at HALT_WORD
    endtask

    initial begin
        int errors;
        // addi x0, x0, k filler, immediate is the word index
        for (int k = 0; k < 2**`RV_IMEM_AW; k++) begin
            imem[k] = {12'(k), 5'd0, 3'b000, 5'd0, 7'b0010011};
        end
        for (int k = 0; k < 2**`RV_DMEM_AW; k++) begin
            dmem[k] = 64'hA5A5_0000_0000_0000 ^ (64'(k) * 64'h0101_0101_0101_0101);
        end
        fill_table();
        build_program();
        built = 1'b1;
        repeat (5) @(posedge clk); // rst_n low for 5 cycles
        rst_n <= 1'b1;
        @(negedge clk);
        // pc is looked at mid cycle, away from the edge that updates it
        while (imem_addr !== `RV_IMEM_AW'(HALT_WORD)) @(negedge clk);
        u_checker.report(errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog, twice the program length plus the reset time
    initial begin
        wait (built);
        #(n_instr * 20 * 2 + 5 * 20);
        $display("timeout: program did not reach the halt loop");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
